//--- sources.f
source/msx_slot_pkg.sv
source/msx_record_pkg.sv
source/upload_sequencer.sv
source/ram_fill_engine.sv
source/slot_layout_writer.sv
source/memory_upload.sv
verification/tb_clock_gen.sv
verification/tb_memory_upload.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory uploader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
   --top-module tb_memory_upload -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_memory_upload)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- verification/tb_memory_upload.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_upload;

   import msx_slot_pkg::*;
   import msx_record_pkg::*;

   localparam int block_shift = 4;
   localparam int num_tests   = 16;
   localparam int timeout     = 20000;     // Cycles per wait

   logic        clk;
   logic        rst_n;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   logic        reset_rq;
   logic [27:0] ddr3_addr;
   logic        ddr3_rd;
   logic  [7:0] ddr3_dout;
   logic        ddr3_ready;
   logic [26:0] ram_addr;
   logic  [7:0] ram_din;
   logic        ram_ce;
   logic        ram_ready;
   slot_entry_t slot_layout [SLOT_ENTRIES];
   ram_ref_t    lookup_ram [RAM_REFS];

   int          seed = 32'h4734aa98;
   logic  [7:0] ddr_mem [1024];
   logic  [7:0] ram_mem [8192];
   int          ram_writes;
   logic        rd_taken;
   logic  [9:0] rd_addr;
   logic        drops_on;              // Random back-pressure enable
   slot_entry_t exp_layout [SLOT_ENTRIES];
   ram_ref_t    exp_lookup [RAM_REFS];
   logic [26:0] alloc_addr;            // Next free RAM byte in the model
   logic [26:0] exp_addr_q [$];
   logic  [7:0] exp_data_q [$];
   string       test_name;
   int          checks;
   int          errors;
   int          tests_failed;
   logic        timed_out;

   tb_clock_gen #(.period_ns(40)) i_clk (.clk);

   memory_upload #(.block_shift(block_shift)) i_dut (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .reset_rq,
      .ddr3_addr, .ddr3_rd, .ddr3_dout, .ddr3_ready,
      .ram_addr, .ram_din, .ram_ce, .ram_ready, .slot_layout, .lookup_ram
   );

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // FF where address bits 8 and 1 are equal
   function automatic logic [7:0] power_on_byte(input logic [26:0] a);
      return (a[8] == a[1]) ? 8'hff : 8'h00;
   endfunction

   task automatic check_slot_entry(input string what, input slot_entry_t exp,
                                   input slot_entry_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_ram_ref(input string what, input ram_ref_t exp, input ram_ref_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_ram_byte(input string what, input logic [7:0] exp,
                                 input logic [7:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic wait_reset_rq(input logic level, output logic ok);
      int cycles;
      cycles = 0;
      while (reset_rq !== level && cycles < timeout) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      ok = reset_rq === level;
   endtask

   // Writes a random image into DDR3 and predicts what the walk leaves behind
   task automatic build_and_predict(output int len);
      int           n;
      int           bad_at;
      int           bad_byte;
      int           blocks;
      int           data_len;
      record_type_t rtype;
      logic   [3:0] slot;
      logic   [3:0] ref_cnt;
      data_id_t     id;
      logic   [7:0] mode;
      logic   [7:0] param;
      logic   [7:0] mapper;
      logic   [7:0] device;
      logic   [1:0] pp;
      logic         live;
      slot_entry_t  old [4];
      slot_entry_t  e;
      n       = 1 + rand_below(4);
      bad_at  = rand_below(3) == 0 ? int'(rand_below(n)) : n;
      len     = 0;
      ref_cnt = 4'd0;
      live    = 1'b1;
      e = '{mapper: mapper_unused, device: device_none, ref_ram: 4'd0, offset_ram: 2'd0};
      foreach (exp_layout[i]) exp_layout[i] = e;
      exp_addr_q.delete();
      exp_data_q.delete();
      for (int r = 0; r < n; r++) begin
         rtype  = rand_below(4) == 0 ? record_slot_b : record_slot_internal;
         slot   = 4'(rand_below(4));           // Few slots, so records overlap
         id     = data_id_t'(rand_below(3));
         blocks = rand_below(5);
         mode   = 8'(rand_below(256));
         param  = 8'(rand_below(256));
         mapper = 8'(rand_below(8));
         device = 8'(rand_below(5));
         ddr_mem[len + 0] = "M";
         ddr_mem[len + 1] = "S";
         ddr_mem[len + 2] = "X";
         if (r == bad_at) begin
            bad_byte = rand_below(3);
            ddr_mem[len + bad_byte] ^= 8'h20;
         end
         ddr_mem[len + 3]  = {rtype, slot};
         ddr_mem[len + 4]  = id;
         ddr_mem[len + 5]  = 8'(blocks >> 8);
         ddr_mem[len + 6]  = 8'(blocks);
         ddr_mem[len + 7]  = device;
         ddr_mem[len + 8]  = mapper;
         ddr_mem[len + 9]  = mode;
         ddr_mem[len + 10] = param;
         for (int k = 11; k < RECORD_BYTES; k++) ddr_mem[len + k] = 8'(rand_below(256));
         data_len = id == data_rom ? blocks << block_shift : 0;
         for (int k = 0; k < data_len; k++) ddr_mem[len + 16 + k] = 8'(rand_below(256));
         if (r == bad_at) live = 1'b0;
         if (live && rtype == record_slot_internal) begin
            if (id != data_none && blocks != 0) begin
               exp_lookup[ref_cnt] = '{addr: alloc_addr, size: 16'(blocks),
                                       ro: id == data_rom};
               for (int k = 0; k < blocks << block_shift; k++) begin
                  exp_addr_q.push_back(alloc_addr);
                  exp_data_q.push_back(id == data_rom ? ddr_mem[len + 16 + k] :
                                       power_on_byte(alloc_addr));
                  alloc_addr++;
               end
            end
            for (int p = 0; p < 4; p++) old[p] = exp_layout[{slot, 2'(p)}];
            for (int p = 0; p < 4; p++) begin
               pp = param[2*p +: 2];
               case (mode[2*p +: 2])
                  2'd1: begin                  // Copy of another page
                     e        = old[pp];
                     e.device = device_none;
                  end
                  2'd2: e = '{mapper: mapper_t'(mapper), device: device_t'(device),
                              ref_ram: ref_cnt, offset_ram: pp};
                  2'd3: e = '{mapper: mapper_unused, device: device_t'(device),
                              ref_ram: ref_cnt, offset_ram: pp};
                  default: e = old[p];
               endcase
               exp_layout[{slot, 2'(p)}] = e;
            end
            if (id != data_none && blocks != 0) ref_cnt++;
         end
         len += RECORD_BYTES + data_len;
      end
   endtask

   // DDR3 requests and RAM writes are sampled mid-cycle
   initial begin
      ram_writes = 0;
      rd_taken   = 1'b0;
      rd_addr    = '0;
      forever begin
         @(negedge clk);
         rd_taken = ddr3_rd && ddr3_ready;   // Taken at the next rising edge
         rd_addr  = ddr3_addr[9:0];
         if (ram_ce) begin
            ram_mem[ram_addr[12:0]] = ram_din;
            ram_writes++;
         end
      end
   end

   initial begin
      ddr3_dout  = '0;
      ddr3_ready = 1'b0;
      ram_ready  = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (rd_taken) ddr3_dout = ddr_mem[rd_addr];
         ddr3_ready = !drops_on || rand_below(4) != 0;
         ram_ready  = !drops_on || rand_below(4) != 0;
      end
   end

   initial begin
      int   before_err;
      int   before_wr;
      int   len;
      logic ok;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      drops_on       = 1'b0;
      checks         = 0;
      errors         = 0;
      tests_failed   = 0;
      timed_out      = 1'b0;
      alloc_addr     = '0;
      exp_lookup     = '{default: '0};
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      #1;
      test_name = "reset";
      if (reset_rq || ddr3_rd || ram_ce) begin
         errors++;
         $display("reset: reset_rq, ddr3_rd or ram_ce is not low after reset");
      end
      foreach (slot_layout[i]) check_slot_entry($sformatf("slot entry %0d", i), '0,
                                                slot_layout[i]);
      foreach (lookup_ram[i]) check_ram_ref($sformatf("lookup %0d", i), '0, lookup_ram[i]);
      if (errors != 0) tests_failed++;
      $display("test reset: %s", errors == 0 ? "pass" : "FAIL");
      for (int t = 0; t < num_tests && !timed_out; t++) begin
         test_name  = $sformatf("walk_%0d", t);
         drops_on   = t % 4 != 0;            // Every fourth walk without back-pressure
         before_err = errors;
         before_wr  = ram_writes;
         @(negedge clk);
         build_and_predict(len);
         @(posedge clk);
         #1;
         ioctl_index    = 16'(CONFIG_INDEX);
         ioctl_addr     = 27'(len);
         ioctl_download = 1'b1;
         @(posedge clk);
         #1 ioctl_download = 1'b0;
         wait_reset_rq(1'b1, ok);
         if (!ok) begin
            $display("test %s: reset_rq never rose after the download ended", test_name);
         end else begin
            wait_reset_rq(1'b0, ok);
            if (!ok) $display("test %s: timeout waiting for reset_rq to fall", test_name);
         end
         if (!ok) begin
            timed_out = 1'b1;
            tests_failed++;
         end else begin
            check_count("RAM write count", exp_addr_q.size(), ram_writes - before_wr);
            foreach (exp_addr_q[i]) begin
               check_ram_byte($sformatf("RAM byte %h", exp_addr_q[i]), exp_data_q[i],
                              ram_mem[exp_addr_q[i][12:0]]);
            end
            foreach (exp_layout[i]) begin
               check_slot_entry($sformatf("slot entry %0d", i), exp_layout[i], slot_layout[i]);
            end
            foreach (exp_lookup[i]) begin
               check_ram_ref($sformatf("lookup %0d", i), exp_lookup[i], lookup_ram[i]);
            end
            if (errors != before_err) tests_failed++;
            $display("test %s: image %0d bytes, %0d RAM bytes, %s", test_name, len,
                     exp_addr_q.size(), errors == before_err ? "pass" : "FAIL");
         end
      end
      $display("tests failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns = 40
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

//--- source/memory_upload.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload #(
   parameter int block_shift = 14
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          ioctl_download,
   input  wire                   [15:0] ioctl_index,
   input  wire                   [26:0] ioctl_addr,
   output logic                         reset_rq,
   output logic                  [27:0] ddr3_addr,
   output logic                         ddr3_rd,
   input  wire                    [7:0] ddr3_dout,
   input  wire                          ddr3_ready,
   output logic                  [26:0] ram_addr,
   output logic                   [7:0] ram_din,
   output logic                         ram_ce,
   input  wire                          ram_ready,
   output msx_slot_pkg::slot_entry_t    slot_layout [msx_slot_pkg::SLOT_ENTRIES],
   output msx_slot_pkg::ram_ref_t       lookup_ram [msx_slot_pkg::RAM_REFS]
);

   import msx_slot_pkg::*;
   import msx_record_pkg::*;

   logic        clear_req, clear_ack;
   logic        fill_req, fill_ack;
   data_id_t    fill_id;
   logic [10:0] fill_blocks;
   logic  [3:0] ref_index;
   logic        src_req, src_ack;
   logic  [7:0] src_data;
   logic        commit_req, commit_ack;
   logic  [3:0] commit_slot, commit_ref;
   logic  [7:0] commit_mode, commit_param;
   mapper_t     commit_mapper;
   device_t     commit_device;

   upload_sequencer #(.block_shift(block_shift)) i_sequencer (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .reset_rq,
      .ddr3_addr, .ddr3_rd, .ddr3_dout, .ddr3_ready,
      .clear_req, .clear_ack,
      .fill_req, .fill_ack, .fill_id, .fill_blocks, .ref_index,
      .src_req, .src_ack, .src_data,
      .commit_req, .commit_ack, .commit_slot, .commit_mode, .commit_param,
      .commit_mapper, .commit_device, .commit_ref
   );

   ram_fill_engine #(.block_shift(block_shift)) i_fill (
      .clk, .rst_n,
      .fill_req, .fill_ack, .fill_id, .fill_blocks, .ref_index,
      .src_req, .src_ack, .src_data,
      .ram_addr, .ram_din, .ram_ce, .ram_ready, .lookup_ram
   );

   slot_layout_writer i_layout (
      .clk, .rst_n, .clear_req, .clear_ack,
      .commit_req, .commit_ack, .commit_slot, .commit_mode, .commit_param,
      .commit_mapper, .commit_device, .commit_ref, .slot_layout
   );

endmodule

`default_nettype wire

//--- source/slot_layout_writer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_layout_writer (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          clear_req,
   output logic                         clear_ack,
   input  wire                          commit_req,
   output logic                         commit_ack,
   input  wire                    [3:0] commit_slot,
   input  wire                    [7:0] commit_mode,
   input  wire                    [7:0] commit_param,
   input  wire msx_slot_pkg::mapper_t   commit_mapper,
   input  wire msx_slot_pkg::device_t   commit_device,
   input  wire                    [3:0] commit_ref,
   output msx_slot_pkg::slot_entry_t    slot_layout [msx_slot_pkg::SLOT_ENTRIES]
);

   import msx_slot_pkg::*;

   logic [5:0] clear_idx;

   function automatic slot_entry_t next_page(input slot_entry_t cur,
                                             input slot_entry_t peer,
                                             input logic [1:0]  pm,
                                             input logic [1:0]  pp);
      slot_entry_t e;
      e = cur;
      case (pm)
         2'd1: begin                       // Mirror another page of this slot
            e.mapper     = peer.mapper;
            e.device     = device_none;
            e.ref_ram    = peer.ref_ram;
            e.offset_ram = peer.offset_ram;
         end
         2'd2: e = '{mapper: commit_mapper, device: commit_device,
                     ref_ram: commit_ref, offset_ram: pp};
         2'd3: e = '{mapper: mapper_unused, device: commit_device,
                     ref_ram: commit_ref, offset_ram: pp};
         default: ;
      endcase
      return e;
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_layout <= '{default: '0};
         clear_idx   <= '0;
         clear_ack   <= 1'b0;
         commit_ack  <= 1'b0;
      end else begin
         if (clear_req && !clear_ack) begin
            slot_layout[clear_idx] <= '{mapper: mapper_unused, device: device_none,
                                        ref_ram: 4'd0, offset_ram: 2'd0};
            clear_idx <= clear_idx + 6'd1;
            if (clear_idx == 6'(SLOT_ENTRIES - 1)) clear_ack <= 1'b1;
         end else if (!clear_req) begin
            clear_ack <= 1'b0;
         end
         if (commit_req && !commit_ack) begin
            for (int p = 0; p < 4; p++) begin  // Peers read the old layout
               slot_layout[{commit_slot, 2'(p)}] <= next_page(
                  slot_layout[{commit_slot, 2'(p)}],
                  slot_layout[{commit_slot, commit_param[2*p +: 2]}],
                  commit_mode[2*p +: 2],
                  commit_param[2*p +: 2]);
            end
            commit_ack <= 1'b1;
         end else if (!commit_req) begin
            commit_ack <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/ram_fill_engine.sv
`timescale 1ns/1ps
`default_nettype none

module ram_fill_engine #(
   parameter int block_shift = 14
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          fill_req,
   output logic                         fill_ack,
   input  wire msx_record_pkg::data_id_t fill_id,
   input  wire                   [10:0] fill_blocks,
   input  wire                    [3:0] ref_index,
   output logic                         src_req,
   input  wire                          src_ack,
   input  wire                    [7:0] src_data,
   output logic                  [26:0] ram_addr,
   output logic                   [7:0] ram_din,
   output logic                         ram_ce,
   input  wire                          ram_ready,
   output msx_slot_pkg::ram_ref_t       lookup_ram [msx_slot_pkg::RAM_REFS]
);

   import msx_record_pkg::*;

   localparam int count_w = 11 + block_shift;

   typedef enum logic [2:0] {st_idle, st_fetch, st_write, st_step, st_done} state_t;

   state_t             state;
   logic [count_w-1:0] count;                  // Bytes still to write
   logic               copy;
   logic         [7:0] data_q;

   // Power-on pattern is FF when address bits 8 and 1 agree
   assign ram_din = copy ? data_q : {8{ram_addr[8] ~^ ram_addr[1]}};

   always_ff @(posedge clk) begin
      if (state == st_fetch && src_ack) data_q <= src_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_idle;
         count      <= '0;
         copy       <= 1'b0;
         ram_addr   <= '0;
         ram_ce     <= 1'b0;
         src_req    <= 1'b0;
         fill_ack   <= 1'b0;
         lookup_ram <= '{default: '0};
      end else begin
         ram_ce <= 1'b0;
         case (state)
            st_idle: if (fill_req) begin
               copy  <= fill_id != data_ram;
               count <= count_w'(fill_blocks) << block_shift;
               if (fill_blocks == 11'd0) begin
                  fill_ack <= 1'b1;
                  state    <= st_done;
               end else begin
                  lookup_ram[ref_index] <= '{addr: ram_addr, size: 16'(fill_blocks),
                                             ro: fill_id != data_ram};
                  src_req <= fill_id != data_ram;
                  state   <= fill_id != data_ram ? st_fetch : st_write;
               end
            end
            st_fetch: if (src_ack) begin
               src_req <= 1'b0;
               state   <= st_write;
            end
            st_write: if (ram_ready && !(copy && src_ack)) begin
               ram_ce <= 1'b1;
               count  <= count - count_w'(1);
               state  <= st_step;
            end
            st_step: begin
               ram_addr <= ram_addr + 27'd1;
               if (count == '0) begin
                  fill_ack <= 1'b1;
                  state    <= st_done;
               end else if (copy) begin
                  src_req <= 1'b1;
                  state   <= st_fetch;
               end else begin
                  state <= st_write;
               end
            end
            st_done: if (!fill_req) begin
               fill_ack <= 1'b0;
               state    <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/upload_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module upload_sequencer #(
   parameter int block_shift = 14
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          ioctl_download,
   input  wire                   [15:0] ioctl_index,
   input  wire                   [26:0] ioctl_addr,
   output logic                         reset_rq,
   output logic                  [27:0] ddr3_addr,
   output logic                         ddr3_rd,
   input  wire                    [7:0] ddr3_dout,
   input  wire                          ddr3_ready,
   output logic                         clear_req,
   input  wire                          clear_ack,
   output logic                         fill_req,
   input  wire                          fill_ack,
   output msx_record_pkg::data_id_t     fill_id,
   output logic                  [10:0] fill_blocks,
   output logic                   [3:0] ref_index,
   input  wire                          src_req,
   output logic                         src_ack,
   output logic                   [7:0] src_data,
   output logic                         commit_req,
   input  wire                          commit_ack,
   output logic                   [3:0] commit_slot,
   output logic                   [7:0] commit_mode,
   output logic                   [7:0] commit_param,
   output msx_slot_pkg::mapper_t        commit_mapper,
   output msx_slot_pkg::device_t        commit_device,
   output logic                   [3:0] commit_ref
);

   import msx_slot_pkg::*;
   import msx_record_pkg::*;

   typedef enum logic [2:0] {
      st_idle, st_clear, st_next, st_header, st_check, st_fill, st_commit
   } state_t;

   state_t      state;
   logic        download_q;
   logic [26:0] image_size;
   logic  [7:0] rec [RECORD_BYTES];
   logic  [3:0] byte_idx;
   logic  [3:0] ref_cnt;
   logic        rd_wait;                   // Byte requested, not yet taken
   logic        byte_ok;
   logic        start;
   logic [27:0] data_len;

   assign start    = download_q && !ioctl_download && ioctl_index == 16'(CONFIG_INDEX);
   assign byte_ok  = rd_wait && !ddr3_rd && ddr3_ready;
   assign reset_rq = state != st_idle;

   assign fill_id       = data_id_t'(rec[REC_DATA_ID]);
   assign fill_blocks   = fill_id == data_none ? 11'd0 :
                          {rec[REC_SIZE_HI][2:0], rec[REC_SIZE_LO]};
   assign data_len      = fill_id == data_rom ? 28'(fill_blocks) << block_shift : 28'd0;
   assign ref_index     = ref_cnt;
   assign commit_ref    = ref_cnt;
   assign commit_slot   = rec[REC_TYPE_SLOT][3:0];
   assign commit_mode   = rec[REC_MODE];
   assign commit_param  = rec[REC_PARAM];
   assign commit_mapper = mapper_t'(rec[REC_MAPPER]);
   assign commit_device = device_t'(rec[REC_DEVICE]);

   always_ff @(posedge clk) begin
      if (state == st_header && byte_ok) rec[byte_idx] <= ddr3_dout;
      if (state == st_fill && byte_ok) src_data <= ddr3_dout;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_idle;
         download_q <= 1'b0;
         image_size <= '0;
         ddr3_addr  <= '0;
         ddr3_rd    <= 1'b0;
         rd_wait    <= 1'b0;
         byte_idx   <= '0;
         ref_cnt    <= '0;
         clear_req  <= 1'b0;
         fill_req   <= 1'b0;
         src_ack    <= 1'b0;
         commit_req <= 1'b0;
      end else begin
         download_q <= ioctl_download;
         if (ddr3_rd && ddr3_ready) begin  // Request taken by DDR3
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 28'd1;
         end
         case (state)
            st_idle: if (start) begin
               image_size <= ioctl_addr;
               ddr3_addr  <= '0;
               ref_cnt    <= '0;
               clear_req  <= 1'b1;
               state      <= st_clear;
            end
            st_clear: if (clear_ack) begin
               clear_req <= 1'b0;
               state     <= st_next;
            end
            st_next: state <= ddr3_addr >= {1'b0, image_size} ? st_idle : st_header;
            st_header: begin
               if (!rd_wait) begin
                  ddr3_rd <= 1'b1;
                  rd_wait <= 1'b1;
               end
               if (byte_ok) begin
                  rd_wait  <= 1'b0;
                  byte_idx <= byte_idx + 4'd1;
                  if (byte_idx == 4'(RECORD_BYTES - 1)) state <= st_check;
               end
            end
            st_check: begin
               if ({rec[0], rec[1], rec[2]} != SIGNATURE) begin
                  state <= st_idle;                             // End of list
               end else if (record_type_t'(rec[REC_TYPE_SLOT][7:4]) != record_slot_internal) begin
                  ddr3_addr <= ddr3_addr + data_len;            // Step over its data
                  state     <= st_next;
               end else begin
                  fill_req <= 1'b1;
                  state    <= st_fill;
               end
            end
            st_fill: begin
               if (src_req && !src_ack && !rd_wait) begin
                  ddr3_rd <= 1'b1;
                  rd_wait <= 1'b1;
               end
               if (byte_ok) begin
                  rd_wait <= 1'b0;
                  src_ack <= 1'b1;
               end
               if (src_ack && !src_req) src_ack <= 1'b0;
               if (fill_ack) begin
                  fill_req   <= 1'b0;
                  commit_req <= 1'b1;
                  state      <= st_commit;
               end
            end
            st_commit: if (commit_ack) begin
               commit_req <= 1'b0;
               if (fill_blocks != 11'd0) ref_cnt <= ref_cnt + 4'd1;
               state <= st_next;
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/msx_record_pkg.sv
`default_nettype none

package msx_record_pkg;

   typedef enum logic [3:0] {
      record_slot_a,
      record_slot_b,
      record_slot_internal,
      record_kbd_layout,
      record_config
   } record_type_t;

   typedef enum logic [7:0] {
      data_none,                           // No fill
      data_rom,                            // Copy following bytes, read only
      data_ram                             // Power-on pattern, writable
   } data_id_t;

   localparam int          RECORD_BYTES = 16;
   localparam int          CONFIG_INDEX = 1;
   localparam logic [23:0] SIGNATURE    = "MSX";

   // Byte offsets inside one record
   localparam int REC_TYPE_SLOT = 3;       // Type high nibble, slot/subslot low
   localparam int REC_DATA_ID   = 4;
   localparam int REC_SIZE_HI   = 5;
   localparam int REC_SIZE_LO   = 6;
   localparam int REC_DEVICE    = 7;
   localparam int REC_MAPPER    = 8;
   localparam int REC_MODE      = 9;
   localparam int REC_PARAM     = 10;

endpackage

`default_nettype wire

//--- source/msx_slot_pkg.sv
`default_nettype none

package msx_slot_pkg;

   typedef enum logic [7:0] {
      mapper_unused,                       // Value left by the clear
      mapper_none,
      mapper_ascii8,
      mapper_ascii16,
      mapper_konami,
      mapper_konami_scc,
      mapper_ram,
      mapper_fmpac
   } mapper_t;

   typedef enum logic [7:0] {
      device_none,
      device_fdc,
      device_opl3,
      device_scc,
      device_scc2
   } device_t;

   typedef struct packed {
      mapper_t     mapper;
      device_t     device;
      logic  [3:0] ref_ram;                // Index into the RAM lookup table
      logic  [1:0] offset_ram;             // Page offset inside the block
   } slot_entry_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;                   // In fill blocks
      logic        ro;
   } ram_ref_t;

   localparam int SLOT_ENTRIES = 64;       // 16 slot/subslot pairs x 4 pages
   localparam int RAM_REFS     = 16;

endpackage

`default_nettype wire
